//--- src/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // datapath and bus widths
    localparam int XLEN      = 64;
    localparam int PADDR_LEN = 32;

    localparam int ROB_IDX_W = 5;
    localparam int PREG_W    = 6;
    localparam int ECAUSE_W  = 4;

    // in-order request queue
    localparam int LSQ_DEPTH = 8;

    typedef logic [XLEN-1:0]              xlen_t;
    typedef logic [PADDR_LEN-1:0]         paddr_t;
    typedef logic [ROB_IDX_W-1:0]         rob_idx_t;
    typedef logic [PREG_W-1:0]            preg_t;
    typedef logic [ECAUSE_W-1:0]          ecause_t;
    typedef logic [XLEN/8-1:0]            byte_sel_t;
    typedef logic [$clog2(LSQ_DEPTH)-1:0] lsq_ptr_t;

    // privileged spec cause codes
    localparam ecause_t ECAUSE_LD_MISALIGN = 4'd4;
    localparam ecause_t ECAUSE_ST_MISALIGN = 4'd6;

    // bit 3 store, bit 2 unsigned load, bits 1:0 log2 of the size
    typedef enum logic [3:0] {
        LB  = 4'b0000,
        LH  = 4'b0001,
        LW  = 4'b0010,
        LD  = 4'b0011,
        LBU = 4'b0100,
        LHU = 4'b0101,
        LWU = 4'b0110,
        SB  = 4'b1000,
        SH  = 4'b1001,
        SW  = 4'b1010,
        SD  = 4'b1011
    } ls_op_e;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        ACCESS = 2'd1,
        COMMIT = 2'd2
    } bus_state_e;

    function automatic logic [1:0] op_size_log2(ls_op_e op);
        logic [3:0] code;
        code = op;
        return code[1:0];
    endfunction

    function automatic logic op_is_store(ls_op_e op);
        logic [3:0] code;
        code = op;
        return code[3];
    endfunction

    function automatic logic op_is_unsigned(ls_op_e op);
        logic [3:0] code;
        code = op;
        return code[2];
    endfunction

endpackage

`default_nettype wire

//--- src/lsu_req_if.sv
`default_nettype none

// one load/store request between internal stages
interface lsu_req_if;
    import lsu_pkg::*;

    logic     vld;
    logic     rdy;
    ls_op_e   op;
    paddr_t   addr;
    xlen_t    data;
    rob_idx_t rob_index;
    preg_t    rd_addr;
    logic     exc;
    ecause_t  ecause;

    modport src (
        output vld, op, addr, data, rob_index, rd_addr, exc, ecause,
        input  rdy
    );

    modport dst (
        input  vld, op, addr, data, rob_index, rd_addr, exc, ecause,
        output rdy
    );

endinterface

`default_nettype wire

//--- src/lsu_issue.sv
`default_nettype none

module lsu_issue (
    input  logic              clk,
    input  logic              rst,
    input  logic              rcu_vld_i,
    input  lsu_pkg::ls_op_e   rcu_op_i,
    input  lsu_pkg::xlen_t    rcu_base_i,
    input  lsu_pkg::xlen_t    rcu_offset_i,
    input  lsu_pkg::rob_idx_t rcu_rob_index_i,
    input  lsu_pkg::preg_t    rcu_rd_addr_i,
    input  lsu_pkg::xlen_t    rcu_data_i,
    output logic              rcu_rdy_o,
    lsu_req_if.src            out
);
    import lsu_pkg::*;

    xlen_t    eff_addr;
    paddr_t   paddr;
    logic     misalign;
    ecause_t  cause;
    logic     accept;

    logic     full_q;
    ls_op_e   op_q;
    paddr_t   addr_q;
    xlen_t    data_q;
    rob_idx_t rob_index_q;
    preg_t    rd_addr_q;
    logic     exc_q;
    ecause_t  ecause_q;

    // no translation, physical address is the low bits of the sum
    assign eff_addr = rcu_base_i + rcu_offset_i;
    assign paddr    = eff_addr[PADDR_LEN-1:0];

    always_comb begin
        case (op_size_log2(rcu_op_i))
            2'd0:    misalign = 1'b0;
            2'd1:    misalign = paddr[0];
            2'd2:    misalign = |paddr[1:0];
            default: misalign = |paddr[2:0];
        endcase
    end

    assign cause = !misalign            ? '0 :
                   op_is_store(rcu_op_i) ? ECAUSE_ST_MISALIGN : ECAUSE_LD_MISALIGN;

    // free slot, or the held item leaves this cycle
    assign rcu_rdy_o = !full_q || out.rdy;
    assign accept    = rcu_vld_i && rcu_rdy_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            full_q <= 1'b0;
        end else if (accept) begin
            full_q <= 1'b1;
        end else if (out.rdy) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q        <= rcu_op_i;
            addr_q      <= paddr;
            data_q      <= rcu_data_i;
            rob_index_q <= rcu_rob_index_i;
            rd_addr_q   <= rcu_rd_addr_i;
            exc_q       <= misalign;
            ecause_q    <= cause;
        end
    end

    assign out.vld       = full_q;
    assign out.op        = op_q;
    assign out.addr      = addr_q;
    assign out.data      = data_q;
    assign out.rob_index = rob_index_q;
    assign out.rd_addr   = rd_addr_q;
    assign out.exc       = exc_q;
    assign out.ecause    = ecause_q;

endmodule

`default_nettype wire

//--- src/lsu_queue.sv
`default_nettype none

module lsu_queue (
    input  logic   clk,
    input  logic   rst,
    lsu_req_if.dst in,
    lsu_req_if.src out
);
    import lsu_pkg::*;

    typedef logic [$clog2(LSQ_DEPTH+1)-1:0] cnt_t;

    // entry storage, one array per field
    ls_op_e   op_mem     [LSQ_DEPTH];
    paddr_t   addr_mem   [LSQ_DEPTH];
    xlen_t    data_mem   [LSQ_DEPTH];
    rob_idx_t rob_mem    [LSQ_DEPTH];
    preg_t    rd_mem     [LSQ_DEPTH];
    logic     exc_mem    [LSQ_DEPTH];
    ecause_t  ecause_mem [LSQ_DEPTH];

    lsq_ptr_t head_q;
    lsq_ptr_t tail_q;
    cnt_t     count_q;
    logic     push;
    logic     pop;

    function automatic lsq_ptr_t ptr_next(lsq_ptr_t ptr);
        return (ptr == lsq_ptr_t'(LSQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // a full queue still takes an item while the head leaves
    assign in.rdy  = (count_q != cnt_t'(LSQ_DEPTH)) || out.rdy;
    assign out.vld = (count_q != '0);

    assign push = in.vld && in.rdy;
    assign pop  = out.vld && out.rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                tail_q <= ptr_next(tail_q);
            end
            if (pop) begin
                head_q <= ptr_next(head_q);
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            op_mem[tail_q]     <= in.op;
            addr_mem[tail_q]   <= in.addr;
            data_mem[tail_q]   <= in.data;
            rob_mem[tail_q]    <= in.rob_index;
            rd_mem[tail_q]     <= in.rd_addr;
            exc_mem[tail_q]    <= in.exc;
            ecause_mem[tail_q] <= in.ecause;
        end
    end

    assign out.op        = op_mem[head_q];
    assign out.addr      = addr_mem[head_q];
    assign out.data      = data_mem[head_q];
    assign out.rob_index = rob_mem[head_q];
    assign out.rd_addr   = rd_mem[head_q];
    assign out.exc       = exc_mem[head_q];
    assign out.ecause    = ecause_mem[head_q];

endmodule

`default_nettype wire

//--- src/lsu_bus_ctrl.sv
`default_nettype none

module lsu_bus_ctrl (
    input  logic               clk,
    input  logic               rst,
    lsu_req_if.dst             in,

    // wishbone classic master
    output logic               wb_cyc_o,
    output logic               wb_stb_o,
    output logic               wb_we_o,
    output lsu_pkg::paddr_t    wb_adr_o,
    output lsu_pkg::xlen_t     wb_dat_o,
    output lsu_pkg::byte_sel_t wb_sel_o,
    input  logic               wb_ack_i,
    input  lsu_pkg::xlen_t     wb_dat_i,

    // commit to ROB
    output logic               comm_vld_o,
    output logic               comm_exception_vld_o,
    output lsu_pkg::rob_idx_t  comm_rob_index_o,
    output lsu_pkg::preg_t     comm_rd_addr_o,
    output lsu_pkg::xlen_t     comm_data_o,
    output lsu_pkg::ecause_t   comm_ecause_o
);
    import lsu_pkg::*;

    bus_state_e state_q;
    bus_state_e state_d;
    logic       accept;

    // the item in service
    ls_op_e     op_q;
    paddr_t     addr_q;
    xlen_t      data_q;
    rob_idx_t   rob_index_q;
    preg_t      rd_addr_q;
    logic       exc_q;
    ecause_t    ecause_q;
    xlen_t      rdata_q;

    logic [5:0] lane_shift;
    byte_sel_t  size_sel;
    xlen_t      rd_aligned;
    xlen_t      load_data;

    assign in.rdy = (state_q == IDLE);
    assign accept = in.vld && in.rdy;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (in.vld) begin
                    // misaligned items never touch the bus
                    state_d = in.exc ? COMMIT : ACCESS;
                end
            end
            ACCESS: begin
                if (wb_ack_i) begin
                    state_d = COMMIT;
                end
            end
            COMMIT:  state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q        <= in.op;
            addr_q      <= in.addr;
            data_q      <= in.data;
            rob_index_q <= in.rob_index;
            rd_addr_q   <= in.rd_addr;
            exc_q       <= in.exc;
            ecause_q    <= in.ecause;
        end
        if (state_q == ACCESS && wb_ack_i) begin
            rdata_q <= wb_dat_i;
        end
    end

    // byte lane steering
    assign lane_shift = {addr_q[2:0], 3'b000};

    always_comb begin
        case (op_size_log2(op_q))
            2'd0:    size_sel = 8'h01;
            2'd1:    size_sel = 8'h03;
            2'd2:    size_sel = 8'h0f;
            default: size_sel = 8'hff;
        endcase
    end

    assign wb_cyc_o = (state_q == ACCESS);
    assign wb_stb_o = (state_q == ACCESS);
    assign wb_we_o  = (state_q == ACCESS) && op_is_store(op_q);
    assign wb_adr_o = {addr_q[PADDR_LEN-1:3], 3'b000};
    assign wb_sel_o = size_sel << addr_q[2:0];
    assign wb_dat_o = data_q << lane_shift;

    // load extraction and extension
    assign rd_aligned = rdata_q >> lane_shift;

    always_comb begin
        case (op_size_log2(op_q))
            2'd0: begin
                load_data = op_is_unsigned(op_q) ? xlen_t'(rd_aligned[7:0]) :
                            {{(XLEN-8){rd_aligned[7]}}, rd_aligned[7:0]};
            end
            2'd1: begin
                load_data = op_is_unsigned(op_q) ? xlen_t'(rd_aligned[15:0]) :
                            {{(XLEN-16){rd_aligned[15]}}, rd_aligned[15:0]};
            end
            2'd2: begin
                load_data = op_is_unsigned(op_q) ? xlen_t'(rd_aligned[31:0]) :
                            {{(XLEN-32){rd_aligned[31]}}, rd_aligned[31:0]};
            end
            default: load_data = rd_aligned;
        endcase
    end

    assign comm_vld_o           = (state_q == COMMIT);
    assign comm_exception_vld_o = (state_q == COMMIT) && exc_q;
    assign comm_rob_index_o     = rob_index_q;
    assign comm_rd_addr_o       = rd_addr_q;
    assign comm_ecause_o        = ecause_q;
    // stores and faulting items return zero
    assign comm_data_o          = (exc_q || op_is_store(op_q)) ? '0 : load_data;

endmodule

`default_nettype wire

//--- src/lsu_top.sv
`default_nettype none

module lsu_top (
    input  logic               clk,
    input  logic               rst,

    // request from rename
    input  logic               rcu_vld_i,
    input  lsu_pkg::ls_op_e    rcu_op_i,
    input  lsu_pkg::xlen_t     rcu_base_i,
    input  lsu_pkg::xlen_t     rcu_offset_i,
    input  lsu_pkg::rob_idx_t  rcu_rob_index_i,
    input  lsu_pkg::preg_t     rcu_rd_addr_i,
    input  lsu_pkg::xlen_t     rcu_data_i,
    output logic               lsu_rdy_o,

    // commit to ROB
    output logic               comm_vld_o,
    output logic               comm_exception_vld_o,
    output lsu_pkg::rob_idx_t  comm_rob_index_o,
    output lsu_pkg::preg_t     comm_rd_addr_o,
    output lsu_pkg::xlen_t     comm_data_o,
    output lsu_pkg::ecause_t   comm_ecause_o,

    // wishbone classic
    output logic               wb_cyc_o,
    output logic               wb_stb_o,
    output logic               wb_we_o,
    output lsu_pkg::paddr_t    wb_adr_o,
    output lsu_pkg::xlen_t     wb_dat_o,
    output lsu_pkg::byte_sel_t wb_sel_o,
    input  logic               wb_ack_i,
    input  lsu_pkg::xlen_t     wb_dat_i
);

    lsu_req_if iss_q ();
    lsu_req_if q_bus ();

    // agu, misalign check, one-entry register
    lsu_issue issue (
        .clk             (clk),
        .rst             (rst),
        .rcu_vld_i       (rcu_vld_i),
        .rcu_op_i        (rcu_op_i),
        .rcu_base_i      (rcu_base_i),
        .rcu_offset_i    (rcu_offset_i),
        .rcu_rob_index_i (rcu_rob_index_i),
        .rcu_rd_addr_i   (rcu_rd_addr_i),
        .rcu_data_i      (rcu_data_i),
        .rcu_rdy_o       (lsu_rdy_o),
        .out             (iss_q.src)
    );

    lsu_queue queue (
        .clk (clk),
        .rst (rst),
        .in  (iss_q.dst),
        .out (q_bus.src)
    );

    lsu_bus_ctrl bus_ctrl (
        .clk                  (clk),
        .rst                  (rst),
        .in                   (q_bus.dst),
        .wb_cyc_o             (wb_cyc_o),
        .wb_stb_o             (wb_stb_o),
        .wb_we_o              (wb_we_o),
        .wb_adr_o             (wb_adr_o),
        .wb_dat_o             (wb_dat_o),
        .wb_sel_o             (wb_sel_o),
        .wb_ack_i             (wb_ack_i),
        .wb_dat_i             (wb_dat_i),
        .comm_vld_o           (comm_vld_o),
        .comm_exception_vld_o (comm_exception_vld_o),
        .comm_rob_index_o     (comm_rob_index_o),
        .comm_rd_addr_o       (comm_rd_addr_o),
        .comm_data_o          (comm_data_o),
        .comm_ecause_o        (comm_ecause_o)
    );

endmodule

`default_nettype wire

//--- testbench/tb_lsu.sv
`default_nettype none

module tb_lsu;
    timeunit 1ns;
    timeprecision 1ps;

    import lsu_pkg::*;

    localparam int    NUM_REQ        = 300;
    localparam int    TIMEOUT_CYCLES = NUM_REQ * 12 + 200;
    // upper bits are dropped by the 32-bit physical address
    localparam xlen_t WIN_BASE       = 64'hffff_0000_8000_1000;

    typedef struct packed {
        xlen_t       data;
        rob_idx_t    rob_index;
        preg_t       rd_addr;
        logic        exc;
        ecause_t     ecause;
        logic [31:0] bus_count;
    } commit_t;

    typedef struct packed {
        paddr_t    adr;
        byte_sel_t sel;
        logic      we;
        xlen_t     dat;
    } bus_t;

    logic      clk;
    logic      rst;
    logic      rcu_vld_i;
    ls_op_e    rcu_op_i;
    xlen_t     rcu_base_i;
    xlen_t     rcu_offset_i;
    rob_idx_t  rcu_rob_index_i;
    preg_t     rcu_rd_addr_i;
    xlen_t     rcu_data_i;
    logic      lsu_rdy_o;
    logic      comm_vld_o;
    logic      comm_exception_vld_o;
    rob_idx_t  comm_rob_index_o;
    preg_t     comm_rd_addr_o;
    xlen_t     comm_data_o;
    ecause_t   comm_ecause_o;
    logic      wb_cyc_o;
    logic      wb_stb_o;
    logic      wb_we_o;
    paddr_t    wb_adr_o;
    xlen_t     wb_dat_o;
    byte_sel_t wb_sel_o;
    logic      wb_ack_i;
    xlen_t     wb_dat_i;

    int        seed;
    int        issued          = 0;
    int        commits         = 0;
    int        bus_done        = 0;
    int        bus_total       = 0;
    int        cycles          = 0;
    int        wait_left       = 0;
    logic      busy            = 1'b0;
    logic      saw_rdy_low     = 1'b0;
    int        value_errors    = 0;
    int        protocol_errors = 0;
    int        final_errors    = 0;
    logic [7:0] slave_mem [256];
    logic [7:0] model_mem [256];
    commit_t   exp_q [$];
    bus_t      bus_q [$];
    ls_op_e    op_list [11] = '{LB, LH, LW, LD, LBU, LHU, LWU, SB, SH, SW, SD};

    lsu_top uut (.*);

    function automatic int rand_below(int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    function automatic int access_size(ls_op_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            LW, LWU, SW: return 4;
            default:     return 8;
        endcase
    endfunction

    function automatic logic is_store(ls_op_e op);
        return op inside {SB, SH, SW, SD};
    endfunction

    task automatic check_equal(input string name, input xlen_t expected, input xlen_t actual);
        assert (expected === actual) else begin
            value_errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic drive_request();
        ls_op_e op;
        int     size;
        int     target;
        longint off;
        op     = op_list[rand_below(11)];
        size   = access_size(op);
        target = rand_below(256) & ~(size - 1);
        // about one in five lands off its natural alignment
        if (rand_below(5) == 0) begin
            if (size == 1) begin
                op     = is_store(op) ? SW : LW;
                size   = 4;
                target = target & ~3;
            end
            target = target + 1 + rand_below(size - 1);
        end
        off = longint'($random(seed) % 128);
        rcu_vld_i       <= 1'b1;
        rcu_op_i        <= op;
        rcu_base_i      <= WIN_BASE + xlen_t'(target) - xlen_t'(off);
        rcu_offset_i    <= xlen_t'(off);
        rcu_rob_index_i <= rob_idx_t'(issued);
        rcu_rd_addr_i   <= preg_t'(rand_below(64));
        rcu_data_i      <= {$random(seed), $random(seed)};
        issued++;
    endtask

    // expected commit in program order, model memory updated at acceptance
    task automatic model_accept();
        paddr_t     addr;
        int         size;
        xlen_t      word;
        logic [7:0] idx;
        commit_t    c;
        bus_t       b;
        addr = paddr_t'(rcu_base_i + rcu_offset_i);
        size = access_size(rcu_op_i);
        c = '0;
        c.rob_index = rcu_rob_index_i;
        c.rd_addr   = rcu_rd_addr_i;
        if ((addr & paddr_t'(size - 1)) != 0) begin
            c.exc    = 1'b1;
            c.ecause = is_store(rcu_op_i) ? ECAUSE_ST_MISALIGN : ECAUSE_LD_MISALIGN;
        end else begin
            bus_total++;
            b.adr = {addr[31:3], 3'b000};
            b.sel = byte_sel_t'(((1 << size) - 1) << addr[2:0]);
            b.we  = is_store(rcu_op_i);
            b.dat = rcu_data_i << (8 * addr[2:0]);
            bus_q.push_back(b);
            word = '0;
            for (int i = 0; i < size; i++) begin
                idx = addr[7:0] + 8'(i);
                if (b.we) begin
                    model_mem[idx] = rcu_data_i[8*i +: 8];
                end else begin
                    word[8*i +: 8] = model_mem[idx];
                end
            end
            // unsigned loads and stores keep the cleared upper bytes
            case (rcu_op_i)
                LB:      c.data = {{56{word[7]}}, word[7:0]};
                LH:      c.data = {{48{word[15]}}, word[15:0]};
                LW:      c.data = {{32{word[31]}}, word[31:0]};
                default: c.data = word;
            endcase
        end
        c.bus_count = 32'(bus_total);
        exp_q.push_back(c);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        seed = 69909;
        rst             <= 1'b1;
        rcu_vld_i       <= 1'b0;
        rcu_op_i        <= LB;
        rcu_base_i      <= '0;
        rcu_offset_i    <= '0;
        rcu_rob_index_i <= '0;
        rcu_rd_addr_i   <= '0;
        rcu_data_i      <= '0;
        wb_ack_i        <= 1'b0;
        wb_dat_i        <= '0;
        for (int i = 0; i < 256; i++) begin
            slave_mem[i] = 8'(i * 29 + 90);
            model_mem[i] = 8'(i * 29 + 90);
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (lsu_rdy_o === 1'b1 && comm_vld_o === 1'b0 && comm_exception_vld_o === 1'b0
                && wb_cyc_o === 1'b0 && wb_stb_o === 1'b0 && wb_we_o === 1'b0) else begin
            final_errors++;
            $display("control outputs are not idle after reset");
        end
        wait (commits == NUM_REQ);
        // late duplicates would show up here
        repeat (10) @(posedge clk);
        assert (exp_q.size() == 0 && bus_q.size() == 0) else begin
            final_errors++;
            $display("%0d expected commits never arrived", exp_q.size());
        end
        assert (saw_rdy_low) else begin
            final_errors++;
            $display("lsu_rdy_o never dropped while a request waited");
        end
        $display("commits %0d, value errors %0d, protocol errors %0d, final errors %0d",
                 commits, value_errors, protocol_errors, final_errors);
        if (value_errors == 0 && protocol_errors == 0 && final_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // request source, a held request stays until it is taken
    always @(posedge clk) begin
        if (!rst) begin
            if (rcu_vld_i && !lsu_rdy_o) begin
                saw_rdy_low = 1'b1;
            end
            if (rcu_vld_i && lsu_rdy_o) begin
                model_accept();
            end
            if (!rcu_vld_i || lsu_rdy_o) begin
                if (issued < NUM_REQ && rand_below(4) != 0) begin
                    drive_request();
                end else begin
                    rcu_vld_i <= 1'b0;
                end
            end
        end
    end

    // wishbone slave with 0 to 5 extra wait cycles
    always @(posedge clk) begin
        xlen_t word;
        bus_t  b;
        if (rst) begin
            wb_ack_i <= 1'b0;
            busy = 1'b0;
        end else begin
            // single-access master, strobe rises and falls with the cycle
            assert (wb_stb_o === wb_cyc_o) else begin
                protocol_errors++;
                $display("wb_stb_o does not follow wb_cyc_o");
            end
            wb_ack_i <= 1'b0;
            if (wb_cyc_o && wb_stb_o && !wb_ack_i) begin
                if (!busy) begin
                    busy = 1'b1;
                    wait_left = rand_below(6);
                end
                if (wait_left == 0) begin
                    busy = 1'b0;
                    bus_done++;
                    assert (bus_q.size() != 0) else begin
                        protocol_errors++;
                        $display("bus cycle started with no aligned access outstanding");
                    end
                    if (bus_q.size() != 0) begin
                        b = bus_q.pop_front();
                        check_equal("wb_adr_o", xlen_t'(b.adr), xlen_t'(wb_adr_o));
                        check_equal("wb_sel_o", xlen_t'(b.sel), xlen_t'(wb_sel_o));
                        check_equal("wb_we_o", xlen_t'(b.we), xlen_t'(wb_we_o));
                        if (b.we) begin
                            check_equal("wb_dat_o", b.dat, wb_dat_o);
                        end
                    end
                    for (int i = 0; i < 8; i++) begin
                        if (wb_we_o && wb_sel_o[i]) begin
                            slave_mem[{wb_adr_o[7:3], 3'(i)}] = wb_dat_o[8*i +: 8];
                        end
                        word[8*i +: 8] = slave_mem[{wb_adr_o[7:3], 3'(i)}];
                    end
                    wb_ack_i <= 1'b1;
                    wb_dat_i <= word;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    always @(posedge clk) begin
        commit_t c;
        if (!rst && comm_vld_o) begin
            commits++;
            assert (exp_q.size() != 0) else begin
                protocol_errors++;
                $display("commit seen with no request outstanding");
            end
            if (exp_q.size() != 0) begin
                c = exp_q.pop_front();
                check_equal("comm_data_o", c.data, comm_data_o);
                check_equal("comm_rob_index_o", xlen_t'(c.rob_index), xlen_t'(comm_rob_index_o));
                check_equal("comm_rd_addr_o", xlen_t'(c.rd_addr), xlen_t'(comm_rd_addr_o));
                check_equal("comm_exception_vld_o", xlen_t'(c.exc),
                            xlen_t'(comm_exception_vld_o));
                if (c.exc) begin
                    check_equal("comm_ecause_o", xlen_t'(c.ecause), xlen_t'(comm_ecause_o));
                end
                // a misaligned item adds no bus cycle
                check_equal("bus cycles before commit", xlen_t'(c.bus_count), xlen_t'(bus_done));
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d commits seen",
                     cycles, commits, NUM_REQ);
            $display("Errors found");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- build.f
src/lsu_pkg.sv
src/lsu_req_if.sv
src/lsu_issue.sv
src/lsu_queue.sv
src/lsu_bus_ctrl.sv
src/lsu_top.sv
testbench/tb_lsu.sv

//--- Makefile
TOP := tb_lsu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "^No errors$$" sim.log || (echo "simulation failed, see sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
